/* verilog/dcachePkg.sv */
// Fixed geometry: 2 ways, 4 sets, 4-word blocks, 32-bit physical byte addresses
// Bus addresses are always word aligned

package dcachePkg;

    // Cache geometry
    localparam int blockWords = 4;
    localparam int numSets = 4;
    localparam int setBits = 2;
    localparam int wordBits = 2;
    localparam int tagBits = 26;

    // Controller state, also seen on the bus side as the bus phase
    localparam logic [1:0] phaseIdle = 2'd0;
    localparam logic [1:0] phaseWriteBack = 2'd1;
    localparam logic [1:0] phaseFetch = 2'd2;

    typedef struct packed {
        logic [tagBits-1:0]  tag;
        logic [setBits-1:0]  set;
        logic [wordBits-1:0] word;
        logic [1:0]          byteOffset;
    } addrFieldsT;

    // One address word, read raw or by field
    typedef union packed {
        logic [31:0] raw;
        addrFieldsT  f;
    } cacheAddrT;

    typedef struct packed {
        cacheAddrT   addr;
        logic [31:0] wdata;
        logic [3:0]  byteMask;
        logic        read;
        logic        write;
    } cacheReqT;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        req;
        logic        write;
    } busReqT;

    typedef struct packed {
        logic                fillWe;
        logic                waySel;
        logic [wordBits-1:0] fillWord;
        logic                hitUpdate;
        logic                lruUpdate;
    } ctrlT;

endpackage

/* verilog/requestDecode.sv */
// Purely combinational
// Bytes outside the write mask come from the bus word, so one merged word
// serves both a refill and a write hit

`timescale 1ns/10ps

module requestDecode
    import dcachePkg::*;
(
    input  cacheReqT    request,
    input  ctrlT        ctrl,
    input  logic [31:0] busRData,
    output cacheAddrT   addr,
    output logic [31:0] writeWord,
    output cacheAddrT   fillAddr
);

    // Field view of the processor address
    assign addr = request.addr;

    // Refill address: request tag and set, word from the controller
    always_comb begin
        fillAddr = request.addr;
        fillAddr.f.word = ctrl.fillWord;
        fillAddr.f.byteOffset = 2'b00;
    end

    // Byte merge
    // On a write hit only the masked bytes are stored, the rest is don't-care
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            if (request.write && request.byteMask[b]) begin
                writeWord[8*b +: 8] = request.wdata[8*b +: 8];
            end else begin
                writeWord[8*b +: 8] = busRData[8*b +: 8];
            end
        end
    end

endmodule

/* verilog/cacheWays.sv */
// Reads are combinational, writes land on the rising clock edge
// Tag and data arrays have no reset; only valid, dirty and LRU bits clear

`timescale 1ns/10ps

module cacheWays
    import dcachePkg::*;
(
    input  logic               clk,
    input  logic               rstN,
    input  cacheAddrT          addr,
    input  cacheAddrT          fillAddr,
    input  logic [31:0]        writeWord,
    input  logic [31:0]        busRData,
    input  ctrlT               ctrl,
    input  cacheReqT           request,
    output logic               hit,
    output logic               hitWay,
    output logic               victimDirty,
    output logic [tagBits-1:0] victimTag,
    output logic [31:0]        wayWord,
    output logic [31:0]        victimWord
);

    logic [tagBits-1:0]      tagMem [2][numSets];
    logic [31:0]             dataMem [2][numSets][blockWords];
    logic [1:0][numSets-1:0] validBits;
    logic [1:0][numSets-1:0] dirtyBits;
    // Per set, the way to evict next
    logic [numSets-1:0]      lruBits;

    logic [setBits-1:0] set;
    logic [1:0]         wayHit;
    logic               victimWay;
    logic               targetWay;
    logic               lastFill;
    logic [31:0]        fillData;

    assign set = addr.f.set;
    assign victimWay = lruBits[set];

    // Tag compare on both ways
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = validBits[w][set] && (tagMem[w][set] == addr.f.tag);
        end
    end

    assign hit = |wayHit;
    assign hitWay = wayHit[1];
    assign wayWord = dataMem[hitWay][set][addr.f.word];

    // Victim view, indexed by the controller's word counter
    assign victimDirty = validBits[victimWay][set] && dirtyBits[victimWay][set];
    assign victimTag = tagMem[victimWay][set];
    assign victimWord = dataMem[victimWay][set][fillAddr.f.word];

    assign targetWay = ctrl.waySel ? victimWay : hitWay;
    assign lastFill = fillAddr.f.word == wordBits'(blockWords - 1);
    // Requested word takes the processor bytes as it arrives
    assign fillData = (fillAddr.f.word == addr.f.word) ? writeWord : busRData;

    always_ff @(posedge clk) begin
        if (ctrl.fillWe) begin
            tagMem[targetWay][set] <= fillAddr.f.tag;
            dataMem[targetWay][set][fillAddr.f.word] <= fillData;
        end else if (ctrl.hitUpdate && request.write) begin
            for (int b = 0; b < 4; b++) begin
                if (request.byteMask[b]) begin
                    dataMem[targetWay][set][addr.f.word][8*b +: 8] <= writeWord[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validBits <= '0;
            dirtyBits <= '0;
            lruBits <= '0;
        end else begin
            if (ctrl.fillWe) begin
                // Block becomes valid only once all four words are in
                validBits[targetWay][set] <= lastFill;
                dirtyBits[targetWay][set] <= 1'b0;
            end else if (ctrl.hitUpdate && request.write) begin
                dirtyBits[targetWay][set] <= 1'b1;
            end
            if (ctrl.lruUpdate) begin
                lruBits[set] <= ~targetWay;
            end
        end
    end

endmodule

/* verilog/missController.sv */
// One miss at a time; the request must stay stable until stall falls
// Each busReady pulse moves exactly one word, four per phase

`timescale 1ns/10ps

module missController
    import dcachePkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic                enable,
    input  logic                hit,
    input  logic                victimDirty,
    input  logic                busReady,
    output logic                stall,
    output ctrlT                ctrl,
    output logic [1:0]          busPhase,
    output logic [wordBits-1:0] wordIndex
);

    logic [1:0]          state;
    logic [1:0]          nextState;
    logic [wordBits-1:0] count;
    logic                missStart;
    logic                lastWord;

    assign missStart = (state == phaseIdle) && enable && !hit;
    // Fourth pulse of the current phase
    assign lastWord = busReady && (count == wordBits'(blockWords - 1));

    always_comb begin
        nextState = state;
        case (state)
            phaseIdle: begin
                if (missStart) begin
                    nextState = victimDirty ? phaseWriteBack : phaseFetch;
                end
            end
            phaseWriteBack: begin
                if (lastWord) begin
                    nextState = phaseFetch;
                end
            end
            phaseFetch: begin
                // Back to idle, the held request then completes as a hit
                if (lastWord) begin
                    nextState = phaseIdle;
                end
            end
            default: begin
                nextState = phaseIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= phaseIdle;
            count <= '0;
        end else begin
            state <= nextState;
            if (state == phaseIdle) begin
                count <= '0;
            end else if (busReady) begin
                // Wraps to zero after the fourth word
                count <= count + 1'b1;
            end
        end
    end

    // Stall rises in the miss cycle itself
    assign stall = (state != phaseIdle) || missStart;

    always_comb begin
        ctrl.fillWe = (state == phaseFetch) && busReady;
        ctrl.waySel = state != phaseIdle;
        ctrl.fillWord = count;
        ctrl.hitUpdate = (state == phaseIdle) && enable && hit;
        // Freshly filled block also counts as recently used
        ctrl.lruUpdate = ctrl.hitUpdate || (ctrl.fillWe && lastWord);
    end

    assign busPhase = state;
    assign wordIndex = count;

endmodule

/* verilog/busPort.sv */
// Purely combinational
// Write data is zero outside the write-back phase

`timescale 1ns/10ps

module busPort
    import dcachePkg::*;
(
    input  logic [1:0]          busPhase,
    input  logic [wordBits-1:0] wordIndex,
    input  cacheAddrT           addr,
    input  logic [tagBits-1:0]  victimTag,
    input  logic [31:0]         victimWord,
    input  logic [31:0]         wayWord,
    output busReqT              busOut,
    output logic [31:0]         readData
);

    cacheAddrT busAddr;
    logic      writeBack;

    assign writeBack = busPhase == phaseWriteBack;

    // Block address: victim tag when evicting, request tag when fetching
    always_comb begin
        busAddr.f.tag = writeBack ? victimTag : addr.f.tag;
        busAddr.f.set = addr.f.set;
        busAddr.f.word = wordIndex;
        busAddr.f.byteOffset = 2'b00;
    end

    always_comb begin
        busOut.addr = busAddr.raw;
        busOut.wdata = writeBack ? victimWord : '0;
        busOut.req = busPhase != phaseIdle;
        busOut.write = writeBack;
    end

    // Hit way word goes straight back to the processor
    assign readData = wayWord;

endmodule

/* verilog/dataCache.sv */
// Two-way write-back data cache between the memory stage and a word bus
// The processor must hold its request while stall is high

`timescale 1ns/10ps

module dataCache
    import dcachePkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        enable,
    input  cacheReqT    request,
    input  logic [31:0] busRData,
    input  logic        busReady,
    output logic [31:0] readData,
    output logic        stall,
    output busReqT      busOut
);

    cacheAddrT           addr;
    cacheAddrT           fillAddr;
    logic [31:0]         writeWord;
    logic [31:0]         wayWord;
    logic [31:0]         victimWord;
    logic [tagBits-1:0]  victimTag;
    logic                hit;
    logic                victimDirty;
    ctrlT                ctrl;
    logic [1:0]          busPhase;
    logic [wordBits-1:0] wordIndex;

    requestDecode requestDecode_i (
        .request   (request),
        .ctrl      (ctrl),
        .busRData  (busRData),
        .addr      (addr),
        .writeWord (writeWord),
        .fillAddr  (fillAddr)
    );

    cacheWays cacheWays_i (
        .clk         (clk),
        .rstN        (rstN),
        .addr        (addr),
        .fillAddr    (fillAddr),
        .writeWord   (writeWord),
        .busRData    (busRData),
        .ctrl        (ctrl),
        .request     (request),
        .hit         (hit),
        .hitWay      (),
        .victimDirty (victimDirty),
        .victimTag   (victimTag),
        .wayWord     (wayWord),
        .victimWord  (victimWord)
    );

    missController missController_i (
        .clk         (clk),
        .rstN        (rstN),
        .enable      (enable),
        .hit         (hit),
        .victimDirty (victimDirty),
        .busReady    (busReady),
        .stall       (stall),
        .ctrl        (ctrl),
        .busPhase    (busPhase),
        .wordIndex   (wordIndex)
    );

    busPort busPort_i (
        .busPhase   (busPhase),
        .wordIndex  (wordIndex),
        .addr       (addr),
        .victimTag  (victimTag),
        .victimWord (victimWord),
        .wayWord    (wayWord),
        .busOut     (busOut),
        .readData   (readData)
    );

endmodule

/* test/busMemModel.sv */
// Word bus memory for the testbench, 256 words at byte addresses 0 to 1023
// Ready follows a request after 0 to 3 idle cycles and lasts one cycle

`timescale 1ns/10ps

module busMemModel
    import dcachePkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  busReqT      busIn,
    output logic        busReady,
    output logic [31:0] busRData
);

    logic [31:0] mem [256];
    logic [7:0]  index;
    logic [1:0]  delayLeft;
    integer      seed;
    integer      r;

    // Fill pattern, every address bit changes the word
    function automatic logic [31:0] initWord(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
    endfunction

    // Upper address bits are ignored
    assign index = busIn.addr[9:2];

    initial begin
        seed = 32'h7644_424b;
        for (int i = 0; i < 256; i++) begin
            mem[i] = initWord(32'(i * 4));
        end
        busReady <= 1'b0;
        busRData <= '0;
        delayLeft <= 2'd0;
    end

    always @(posedge clk) begin
        if (!rstN) begin
            busReady <= 1'b0;
            delayLeft <= 2'd0;
        end else if (busReady) begin
            // Pulse lasts one cycle
            busReady <= 1'b0;
        end else if (busIn.req) begin
            if (delayLeft != 2'd0) begin
                delayLeft <= delayLeft - 2'd1;
            end else begin
                r = $random(seed);
                delayLeft <= r[1:0];
                busReady <= 1'b1;
                // Address and data hold through the pulse cycle
                if (busIn.write) begin
                    mem[index] = busIn.wdata;
                end else begin
                    busRData <= mem[index];
                end
            end
        end
    end

endmodule

/* test/dataCacheTb.sv */
// Self-checking testbench for the two-way data cache
// Addresses use tags 0 to 15 only, so that they fit the 256-word bus model

`timescale 1ns/10ps

module dataCacheTb
    import dcachePkg::*;
();

    logic        clk;
    logic        rstN;
    logic        enable;
    cacheReqT    request;
    logic [31:0] busRData;
    logic        busReady;
    logic [31:0] readData;
    logic        stall;
    busReqT      busOut;

    // Expected memory contents, seeded from the bus model during reset
    logic [31:0] shadow [256];
    string       testName;
    integer      seed;
    int          mismatches;
    int          timeouts;
    logic        hung;

    dataCache dataCache_i (
        .clk      (clk),
        .rstN     (rstN),
        .enable   (enable),
        .request  (request),
        .busRData (busRData),
        .busReady (busReady),
        .readData (readData),
        .stall    (stall),
        .busOut   (busOut)
    );

    busMemModel memModel_i (
        .clk      (clk),
        .rstN     (rstN),
        .busIn    (busOut),
        .busReady (busReady),
        .busRData (busRData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("** Error: %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] makeAddr(input int tag, input int set, input int word);
        cacheAddrT a;
        a.f.tag = tagBits'(tag);
        a.f.set = setBits'(set);
        a.f.word = wordBits'(word);
        a.f.byteOffset = 2'b00;
        return a.raw;
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] old,
                                               input logic [31:0] data,
                                               input logic [3:0] mask);
        logic [31:0] result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = data[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Reference model: last masked write, else the initial pattern
    function automatic logic [31:0] expectedWord(input logic [31:0] a);
        return shadow[a[9:2]];
    endfunction

    // Comparing process, one completed access per edge at most
    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 256; i++) begin
                shadow[i] = memModel_i.mem[i];
            end
        end else if (enable && !stall) begin
            if (request.read) begin
                checkValue(testName, expectedWord(request.addr.raw), readData);
            end
            if (request.write) begin
                shadow[request.addr.raw[9:2]] = mergeBytes(expectedWord(request.addr.raw),
                                                           request.wdata, request.byteMask);
            end
        end
    end

    // Called right after a rising edge; returns at the edge that completes the access
    task automatic runAccess(input string name, input logic [31:0] a, input logic wr,
                             input logic [31:0] data, input logic [3:0] mask,
                             output int cycles);
        cacheReqT req;
        cycles = 0;
        if (hung) begin
            return;
        end
        req.addr.raw = a;
        req.wdata = data;
        req.byteMask = mask;
        req.read = !wr;
        req.write = wr;
        testName <= name;
        enable <= 1'b1;
        request <= req;
        do begin
            @(posedge clk);
            cycles++;
        end while (stall && cycles < 500);
        if (stall) begin
            timeouts++;
            hung = 1'b1;
            $display("Timeout: stall stayed high for 500 cycles in %s", name);
        end
    endtask

    task automatic readAt(input string name, input logic [31:0] a, output int cycles);
        runAccess(name, a, 1'b0, 32'd0, 4'b0000, cycles);
    endtask

    task automatic writeAt(input string name, input logic [31:0] a, input logic [31:0] data,
                           input logic [3:0] mask, output int cycles);
        runAccess(name, a, 1'b1, data, mask, cycles);
    endtask

    initial begin
        int          cycles;
        int          r;
        logic [31:0] d;

        seed = 32'h7644_424b;
        mismatches = 0;
        timeouts = 0;
        hung = 1'b0;
        rstN <= 1'b0;
        enable <= 1'b0;
        request <= '0;
        testName <= "reset";
        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        // Idle after reset, no request yet
        repeat (3) begin
            @(posedge clk);
            checkValue("reset stall", 32'd0, 32'(stall));
            checkValue("reset bus request", 32'd0, 32'(busOut.req));
            checkValue("reset bus write", 32'd0, 32'(busOut.write));
        end

        readAt("read miss", makeAddr(1, 0, 2), cycles);
        checkValue("read miss stalls", 32'd1, 32'(cycles > 1));
        for (int w = 0; w < 4; w++) begin
            readAt("read hit", makeAddr(1, 0, w), cycles);
            checkValue("read hit without stall", 32'd1, 32'(cycles));
        end

        writeAt("masked write hit", makeAddr(1, 0, 1), 32'hA1B2_C3D4, 4'b0101, cycles);
        checkValue("masked write hit without stall", 32'd1, 32'(cycles));
        writeAt("masked write hit", makeAddr(1, 0, 2), 32'h1122_3344, 4'b1000, cycles);
        readAt("masked write readback", makeAddr(1, 0, 1), cycles);
        readAt("masked write readback", makeAddr(1, 0, 2), cycles);

        writeAt("write miss", makeAddr(2, 1, 3), 32'hDEAD_BEEF, 4'b0110, cycles);
        checkValue("write miss stalls", 32'd1, 32'(cycles > 1));
        readAt("write miss readback", makeAddr(2, 1, 3), cycles);
        readAt("write miss readback", makeAddr(2, 1, 0), cycles);

        // LRU in set 2 with A = tag 0, B = tag 1, C = tag 3
        readAt("lru fill A", makeAddr(0, 2, 0), cycles);
        readAt("lru fill B", makeAddr(1, 2, 1), cycles);
        readAt("lru touch A", makeAddr(0, 2, 2), cycles);
        readAt("lru fill C", makeAddr(3, 2, 3), cycles);
        readAt("lru read A", makeAddr(0, 2, 1), cycles);
        checkValue("lru keeps A", 32'd1, 32'(cycles));
        readAt("lru read B", makeAddr(1, 2, 0), cycles);
        checkValue("lru evicted B", 32'd1, 32'(cycles > 1));

        // Four tags per set over two ways forces dirty evictions
        for (int n = 0; n < 80; n++) begin
            r = $random(seed);
            d = $random(seed);
            if (r[6]) begin
                writeAt("random write", makeAddr(r & 3, (r >> 2) & 3, (r >> 4) & 3), d,
                        4'(r >> 8), cycles);
            end else begin
                readAt("random read", makeAddr(r & 3, (r >> 2) & 3, (r >> 4) & 3), cycles);
            end
        end

        // Tags 8 and 9 push every dirty block out to the bus
        for (int s = 0; s < numSets; s++) begin
            readAt("flush read", makeAddr(8, s, 0), cycles);
            readAt("flush read", makeAddr(9, s, 0), cycles);
        end
        enable <= 1'b0;
        @(posedge clk);
        if (!hung) begin
            for (int i = 0; i < 256; i++) begin
                checkValue($sformatf("memory word %0d", i), shadow[i], memModel_i.mem[i]);
            end
        end

        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/dcachePkg.sv
verilog/requestDecode.sv
verilog/cacheWays.sv
verilog/missController.sv
verilog/busPort.sv
verilog/dataCache.sv
test/busMemModel.sv
test/dataCacheTb.sv

/* run.sh */
#!/bin/sh
# Builds the cache testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps -f project.f \
    --top-module dataCacheTb -o simDataCache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simDataCache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0
